// File: hw/axi_bridge_pkg.sv
`default_nettype none

//////////////////////////////////////////////////////////////////////
// AXI4 write bridge shared definitions
//////////////////////////////////////////////////////////////////////

package axi_bridge_pkg;

    // Byte address into the accelerator window
    localparam int AXI_ADDR_WTH = 29;

    // One beat is 8 bytes
    // INCR burst type and full strobe come from the system tie-off
    localparam int AXI_DATA_WTH = 64;

    // Write ID, one outstanding burst per value
    localparam int AXI_ID_WTH   = 4;

    // AXI4 awlen field
    // Holds beat count minus one, so up to 256 beats per burst
    localparam int AXI_LEN_WTH  = 8;

    //////////////////////////////////////////////////////////////////////
    // Lookaside sizing
    //////////////////////////////////////////////////////////////////////

    // One table entry per distinct ID
    localparam int MAX_N_TAGS   = 2 ** AXI_ID_WTH;

    // Number of entries equals the ID space so bid indexes directly
    // Widen AXI_ID_WTH and MAX_N_TAGS follows

endpackage

`default_nettype wire

// File: hw/wr_client_select.sv
`timescale 1ns/100ps
`default_nettype none

module wr_client_select
    import axi_bridge_pkg::*;
#(
    parameter int NUM_WR_CLIENTS = 4
) (
    input  wire                                     clk,
    input  wire                                     rst,
    // Client request side, client k in slice k
    input  wire  [NUM_WR_CLIENTS-1:0]               wr_req,
    input  wire  [NUM_WR_CLIENTS*AXI_ID_WTH-1:0]    wr_req_id,
    input  wire  [NUM_WR_CLIENTS*AXI_ADDR_WTH-1:0]  wr_addr,
    input  wire  [NUM_WR_CLIENTS*AXI_LEN_WTH-1:0]   wr_len,
    input  wire  [NUM_WR_CLIENTS*AXI_DATA_WTH-1:0]  wr_data,
    input  wire  [NUM_WR_CLIENTS-1:0]               wr_data_vld,
    // Control from the FSM
    input  wire                                     arb_take,
    input  wire                                     aw_fire,
    input  wire                                     beat_fire,
    input  wire                                     wready,
    // Towards FSM, lookaside and AXI
    output logic                                    any_req,
    output logic [$clog2(NUM_WR_CLIENTS)-1:0]       grant_idx,
    output logic [AXI_ID_WTH-1:0]                   sel_id,
    output logic [AXI_ADDR_WTH-1:0]                 sel_addr,
    output logic [AXI_LEN_WTH-1:0]                  sel_len,
    output logic [AXI_DATA_WTH-1:0]                 sel_data,
    output logic                                    sel_data_vld,
    // Handshakes back to the clients
    output logic [NUM_WR_CLIENTS-1:0]               wr_req_ack,
    output logic [NUM_WR_CLIENTS-1:0]               wr_data_rdy
);

    localparam int IDX_WTH = $clog2(NUM_WR_CLIENTS);

    logic [IDX_WTH-1:0] rr_ptr;     // Where the next search starts
    logic [IDX_WTH-1:0] next_idx;   // First requester at or after rr_ptr

    //////////////////////////////////////////////////////////////////////
    // Round-robin search
    //////////////////////////////////////////////////////////////////////

    assign any_req = |wr_req;

    always_comb begin
        int   cand;
        logic found;
        cand     = 0;
        found    = 1'b0;
        next_idx = rr_ptr;                                  // Held when nobody asks
        for (int k = 0; k < NUM_WR_CLIENTS; k++) begin
            cand = (int'(rr_ptr) + k) % NUM_WR_CLIENTS;     // Wrap past the top client
            if (!found && wr_req[cand]) begin
                found    = 1'b1;
                next_idx = IDX_WTH'(cand);
            end
        end
    end

    // Winner latched once per burst, pointer moves past it
    always_ff @(posedge clk) begin
        if (rst) begin
            rr_ptr    <= '0;
            grant_idx <= '0;
        end else if (arb_take) begin
            grant_idx <= next_idx;
            if (next_idx == IDX_WTH'(NUM_WR_CLIENTS - 1)) begin
                rr_ptr <= '0;
            end else begin
                rr_ptr <= next_idx + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Winner field mux and handshake steering
    //////////////////////////////////////////////////////////////////////

    assign sel_id       = wr_req_id[grant_idx*AXI_ID_WTH +: AXI_ID_WTH];
    assign sel_addr     = wr_addr[grant_idx*AXI_ADDR_WTH +: AXI_ADDR_WTH];
    assign sel_len      = wr_len[grant_idx*AXI_LEN_WTH +: AXI_LEN_WTH];
    assign sel_data     = wr_data[grant_idx*AXI_DATA_WTH +: AXI_DATA_WTH];
    assign sel_data_vld = wr_data_vld[grant_idx];

    always_comb begin
        wr_req_ack             = '0;
        wr_data_rdy            = '0;
        wr_req_ack[grant_idx]  = aw_fire;                   // Request retired at AW handshake
        wr_data_rdy[grant_idx] = beat_fire;                 // Only the winner sees wready
    end

    // FSM only arbitrates with someone waiting
    a_take_has_req: assert property (@(posedge clk) disable iff (rst)
        arb_take |-> any_req);

    // A beat moves only when the slave and the winning client are both ready
    a_beat_is_handshake: assert property (@(posedge clk) disable iff (rst)
        beat_fire |-> (wready && sel_data_vld));

endmodule

`default_nettype wire

// File: hw/wr_burst_counter.sv
`timescale 1ns/100ps
`default_nettype none

module wr_burst_counter
    import axi_bridge_pkg::*;
(
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     aw_fire,    // Load point
    input  wire [AXI_LEN_WTH-1:0]   sel_len,    // Beats minus one
    input  wire                     beat_fire,  // One data handshake
    output logic                    last_beat
);

    logic [AXI_LEN_WTH-1:0] beats_left;     // Beats still to go after the current one
    logic                   burst_loaded;   // Burst between AW and its final beat

    //////////////////////////////////////////////////////////////////////
    // Remaining beat count
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            beats_left   <= '0;
            burst_loaded <= 1'b0;
        end else if (aw_fire) begin
            beats_left   <= sel_len;                // awlen already is count minus one
            burst_loaded <= 1'b1;
        end else if (beat_fire) begin
            if (last_beat) begin
                burst_loaded <= 1'b0;               // Burst done
            end else begin
                beats_left <= beats_left - 1'b1;
            end
        end
    end

    // Zero remaining means the beat on the bus is the final one
    assign last_beat = (beats_left == '0);

    // Data never moves outside a loaded burst
    a_beat_in_burst: assert property (@(posedge clk) disable iff (rst)
        beat_fire |-> burst_loaded);

    // Next address phase only after the previous final beat
    a_no_overlap: assert property (@(posedge clk) disable iff (rst)
        aw_fire |-> !burst_loaded);

endmodule

`default_nettype wire

// File: hw/wr_channel_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module wr_channel_fsm (
    input  wire     clk,
    input  wire     rst,
    input  wire     any_req,        // Some client waiting
    input  wire     awready,
    input  wire     wready,
    input  wire     sel_data_vld,   // Winner has a beat ready
    input  wire     last_beat,      // From the beat counter
    output logic    arb_take,
    output logic    aw_fire,
    output logic    beat_fire,
    output logic    awvalid,
    output logic    wvalid,
    output logic    wlast
);

    //////////////////////////////////////////////////////////////////////
    // State encoding
    //////////////////////////////////////////////////////////////////////

    localparam logic [1:0] ST_IDLE = 2'd0;     // Waiting for a request
    localparam logic [1:0] ST_ADDR = 2'd1;     // AW channel valid
    localparam logic [1:0] ST_DATA = 2'd2;     // Streaming W beats

    logic [1:0] state;
    logic [1:0] state_nxt;

    //////////////////////////////////////////////////////////////////////
    // Channel outputs
    //////////////////////////////////////////////////////////////////////

    assign arb_take  = (state == ST_IDLE) && any_req;   // Selector latches winner
    assign awvalid   = (state == ST_ADDR);
    assign aw_fire   = awvalid && awready;
    assign wvalid    = (state == ST_DATA) && sel_data_vld;
    assign wlast     = (state == ST_DATA) && last_beat;
    assign beat_fire = wvalid && wready;

    // Next state
    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (any_req) begin
                    state_nxt = ST_ADDR;
                end
            end
            ST_ADDR: begin
                if (aw_fire) begin
                    state_nxt = ST_DATA;                // First wvalid one cycle later
                end
            end
            ST_DATA: begin
                if (beat_fire && last_beat) begin
                    state_nxt = ST_IDLE;                // One idle cycle before next AW
                end
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Address valid held through slave back-pressure
    a_awvalid_held: assert property (@(posedge clk) disable iff (rst)
        (awvalid && !awready) |=> awvalid);

endmodule

`default_nettype wire

// File: hw/wr_tag_lookaside.sv
`timescale 1ns/100ps
`default_nettype none

module wr_tag_lookaside
    import axi_bridge_pkg::*;
#(
    parameter int NUM_WR_CLIENTS = 4
) (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire                                 aw_fire,    // Write point
    input  wire [AXI_ID_WTH-1:0]                sel_id,     // AWID of the issued burst
    input  wire [$clog2(NUM_WR_CLIENTS)-1:0]    grant_idx,  // Owner of that burst
    input  wire                                 bvalid,
    input  wire [AXI_ID_WTH-1:0]                bid,
    output logic [NUM_WR_CLIENTS-1:0]           wr_cmpl
);

    localparam int IDX_WTH = $clog2(NUM_WR_CLIENTS);

    logic [IDX_WTH-1:0]    tag_client [MAX_N_TAGS];   // Owner per ID
    logic [MAX_N_TAGS-1:0] tag_vld;                   // Burst outstanding per ID

    //////////////////////////////////////////////////////////////////////
    // Table update
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            tag_vld <= '0;
        end else begin
            if (bvalid) begin
                tag_vld[bid] <= 1'b0;               // bready tied high so bvalid retires
            end
            if (aw_fire) begin
                tag_vld[sel_id] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            tag_client[sel_id] <= grant_idx;
        end
    end

    // Response routing, same cycle as bvalid
    always_comb begin
        wr_cmpl                  = '0;
        wr_cmpl[tag_client[bid]] = bvalid && tag_vld[bid];
    end

    // Every response belongs to an issued burst
    a_bid_known: assert property (@(posedge clk) disable iff (rst)
        bvalid |-> tag_vld[bid]);

    // Clients never reuse an ID still in flight
    a_id_free: assert property (@(posedge clk) disable iff (rst)
        aw_fire |-> !tag_vld[sel_id]);

endmodule

`default_nettype wire

// File: hw/axi_wr_bridge_top.sv
`timescale 1ns/100ps
`default_nettype none

module axi_wr_bridge_top
    import axi_bridge_pkg::*;
#(
    parameter int NUM_WR_CLIENTS = 4
) (
    input  wire                                     clk,
    input  wire                                     rst,
    //////////////////////////////////////////////////////////////////////
    // Write clients
    //////////////////////////////////////////////////////////////////////
    input  wire  [NUM_WR_CLIENTS-1:0]               wr_req,
    input  wire  [NUM_WR_CLIENTS*AXI_ID_WTH-1:0]    wr_req_id,
    input  wire  [NUM_WR_CLIENTS*AXI_ADDR_WTH-1:0]  wr_addr,
    input  wire  [NUM_WR_CLIENTS*AXI_LEN_WTH-1:0]   wr_len,
    input  wire  [NUM_WR_CLIENTS*AXI_DATA_WTH-1:0]  wr_data,
    input  wire  [NUM_WR_CLIENTS-1:0]               wr_data_vld,
    output logic [NUM_WR_CLIENTS-1:0]               wr_req_ack,
    output logic [NUM_WR_CLIENTS-1:0]               wr_data_rdy,
    output logic [NUM_WR_CLIENTS-1:0]               wr_cmpl,
    //////////////////////////////////////////////////////////////////////
    // AXI4 write port
    //////////////////////////////////////////////////////////////////////
    input  wire                                     awready,
    output logic                                    awvalid,
    output logic [AXI_ID_WTH-1:0]                   awid,
    output logic [AXI_ADDR_WTH-1:0]                 awaddr,
    output logic [AXI_LEN_WTH-1:0]                  awlen,
    input  wire                                     wready,
    output logic                                    wvalid,
    output logic [AXI_DATA_WTH-1:0]                 wdata,
    output logic                                    wlast,
    input  wire                                     bvalid,
    input  wire  [AXI_ID_WTH-1:0]                   bid,
    output logic                                    bready
);

    localparam int IDX_WTH = $clog2(NUM_WR_CLIENTS);

    logic               any_req;
    logic [IDX_WTH-1:0] grant_idx;      // Current burst owner
    logic               sel_data_vld;
    logic               arb_take;
    logic               aw_fire;
    logic               beat_fire;
    logic               last_beat;

    assign bready = 1'b1;               // Responses always accepted

    wr_client_select #(.NUM_WR_CLIENTS(NUM_WR_CLIENTS)) i_select (
        .clk(clk), .rst(rst),
        .wr_req(wr_req), .wr_req_id(wr_req_id), .wr_addr(wr_addr),
        .wr_len(wr_len), .wr_data(wr_data), .wr_data_vld(wr_data_vld),
        .arb_take(arb_take), .aw_fire(aw_fire), .beat_fire(beat_fire),
        .wready(wready), .any_req(any_req), .grant_idx(grant_idx),
        .sel_id(awid), .sel_addr(awaddr), .sel_len(awlen),
        .sel_data(wdata), .sel_data_vld(sel_data_vld),
        .wr_req_ack(wr_req_ack), .wr_data_rdy(wr_data_rdy)
    );

    wr_burst_counter i_counter (
        .clk(clk), .rst(rst), .aw_fire(aw_fire), .sel_len(awlen),
        .beat_fire(beat_fire), .last_beat(last_beat)
    );

    wr_channel_fsm i_fsm (
        .clk(clk), .rst(rst), .any_req(any_req), .awready(awready),
        .wready(wready), .sel_data_vld(sel_data_vld), .last_beat(last_beat),
        .arb_take(arb_take), .aw_fire(aw_fire), .beat_fire(beat_fire),
        .awvalid(awvalid), .wvalid(wvalid), .wlast(wlast)
    );

    // Owner table for out-of-order responses
    wr_tag_lookaside #(.NUM_WR_CLIENTS(NUM_WR_CLIENTS)) i_lookaside (
        .clk(clk), .rst(rst), .aw_fire(aw_fire), .sel_id(awid),
        .grant_idx(grant_idx), .bvalid(bvalid), .bid(bid), .wr_cmpl(wr_cmpl)
    );

endmodule

`default_nettype wire

// File: tests/tb_axi_wr_bridge.sv
`timescale 1ns/100ps
`default_nettype none

module tb_axi_wr_bridge
    import axi_bridge_pkg::*;
();

    localparam int N_CLIENTS  = 4;
    localparam int CLK_PERIOD = 4;
    localparam int N_FIELDS   = 8;      // Columns per golden record
    localparam int MAX_RECS   = 32;

    // Golden record columns
    localparam int F_TEST   = 0;
    localparam int F_CLIENT = 1;
    localparam int F_ID     = 2;
    localparam int F_ADDR   = 3;
    localparam int F_LEN    = 4;        // Beats minus one
    localparam int F_BASE   = 5;        // Data of beat 0
    localparam int F_ORDER  = 6;        // Address phase slot in the test
    localparam int F_DELAY  = 7;        // Cycles from last beat to response

    logic                               clk = 1'b0;
    logic                               rst;
    logic [N_CLIENTS-1:0]               wr_req;
    logic [N_CLIENTS*AXI_ID_WTH-1:0]    wr_req_id;
    logic [N_CLIENTS*AXI_ADDR_WTH-1:0]  wr_addr;
    logic [N_CLIENTS*AXI_LEN_WTH-1:0]   wr_len;
    logic [N_CLIENTS*AXI_DATA_WTH-1:0]  wr_data;
    logic [N_CLIENTS-1:0]               wr_data_vld;
    logic [N_CLIENTS-1:0]               wr_req_ack;
    logic [N_CLIENTS-1:0]               wr_data_rdy;
    logic [N_CLIENTS-1:0]               wr_cmpl;
    logic                               awready;
    logic                               awvalid;
    logic [AXI_ID_WTH-1:0]              awid;
    logic [AXI_ADDR_WTH-1:0]            awaddr;
    logic [AXI_LEN_WTH-1:0]             awlen;
    logic                               wready;
    logic                               wvalid;
    logic [AXI_DATA_WTH-1:0]            wdata;
    logic                               wlast;
    logic                               bvalid;
    logic [AXI_ID_WTH-1:0]              bid;
    logic                               bready;

    //////////////////////////////////////////////////////////////////////
    // Model state
    //////////////////////////////////////////////////////////////////////

    logic [63:0]            golden_mem [MAX_RECS*N_FIELDS];
    int                     n_recs = 0;
    int                     grp [$];            // Records of the running test
    int                     issued_cnt;         // Address phases seen so far
    int                     cur_rec = -1;       // Burst on the W channel
    int                     exp_beat;
    int                     beats_seen [MAX_RECS];
    int                     cmpl_seen [MAX_RECS];
    int                     cl_rec [N_CLIENTS]; // Burst each client drives or -1
    int                     cl_beat [N_CLIENTS];
    logic [N_CLIENTS-1:0]   cl_req;
    int                     resp_rec [$];       // Slave's open responses
    int                     resp_due [$];
    int                     b_rec = -1;         // Response on B this cycle
    int                     cycle_cnt = 0;
    logic                   aw_held = 1'b0;     // AW stalled last cycle
    logic [AXI_ID_WTH-1:0]  held_id;
    logic [AXI_ADDR_WTH-1:0] held_addr;
    logic [AXI_LEN_WTH-1:0] held_len;
    int                     checks = 0;
    int                     errors = 0;
    int                     test_errs = 0;
    int                     tests_run = 0;
    int                     tests_failed = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    axi_wr_bridge_top #(.NUM_WR_CLIENTS(N_CLIENTS)) i_dut (
        .clk(clk), .rst(rst),
        .wr_req(wr_req), .wr_req_id(wr_req_id), .wr_addr(wr_addr), .wr_len(wr_len),
        .wr_data(wr_data), .wr_data_vld(wr_data_vld), .wr_req_ack(wr_req_ack),
        .wr_data_rdy(wr_data_rdy), .wr_cmpl(wr_cmpl),
        .awready(awready), .awvalid(awvalid), .awid(awid), .awaddr(awaddr), .awlen(awlen),
        .wready(wready), .wvalid(wvalid), .wdata(wdata), .wlast(wlast),
        .bvalid(bvalid), .bid(bid), .bready(bready)
    );

    function automatic logic [63:0] golden_field(input int rec, input int col);
        return golden_mem[rec*N_FIELDS + col];
    endfunction

    // One-hot of the client that owns a record
    function automatic logic [N_CLIENTS-1:0] client_bit(input int rec);
        return N_CLIENTS'(1) << golden_field(rec, F_CLIENT);
    endfunction

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            test_errs++;
            $display("[ERROR] %0d ns: %s is %0h, expected %0h",
                     $time, what, actual, expected);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Client and slave drive on the falling edge
    //////////////////////////////////////////////////////////////////////

    task automatic drive_inputs();
        int r;
        int pick;
        cycle_cnt++;
        awready = ($urandom % 4) != 0;              // About one stall in four
        wready  = ($urandom % 4) != 0;
        for (int k = 0; k < N_CLIENTS; k++) begin
            r              = cl_rec[k];
            wr_req[k]      = cl_req[k];
            wr_data_vld[k] = 1'b0;
            if (r >= 0) begin
                wr_req_id[k*AXI_ID_WTH +: AXI_ID_WTH]   = AXI_ID_WTH'(golden_field(r, F_ID));
                wr_addr[k*AXI_ADDR_WTH +: AXI_ADDR_WTH] = AXI_ADDR_WTH'(golden_field(r, F_ADDR));
                wr_len[k*AXI_LEN_WTH +: AXI_LEN_WTH]    = AXI_LEN_WTH'(golden_field(r, F_LEN));
                wr_data[k*AXI_DATA_WTH +: AXI_DATA_WTH] = golden_field(r, F_BASE) + 64'(cl_beat[k]);
                wr_data_vld[k] = cl_beat[k] <= int'(golden_field(r, F_LEN));
            end
        end
        // Only the earliest due response goes out
        pick = -1;
        for (int i = 0; i < resp_due.size(); i++) begin
            if (resp_due[i] <= cycle_cnt && (pick < 0 || resp_due[i] < resp_due[pick])) begin
                pick = i;
            end
        end
        b_rec  = -1;
        bvalid = 1'b0;
        if (pick >= 0) begin
            b_rec  = resp_rec[pick];
            bvalid = 1'b1;
            bid    = AXI_ID_WTH'(golden_field(b_rec, F_ID));
            resp_rec.delete(pick);
            resp_due.delete(pick);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Checks just before the rising edge
    //////////////////////////////////////////////////////////////////////

    task automatic sample_outputs();
        int                   r;
        logic [N_CLIENTS-1:0] exp_bits;
        if (aw_held) begin                          // Fields frozen under awready stall
            check_value(64'(awvalid), 64'(1), "awvalid under stall");
            check_value(64'(awid), 64'(held_id), "awid under stall");
            check_value(64'(awaddr), 64'(held_addr), "awaddr under stall");
            check_value(64'(awlen), 64'(held_len), "awlen under stall");
        end
        aw_held   = awvalid && !awready;
        held_id   = awid;
        held_addr = awaddr;
        held_len  = awlen;
        exp_bits  = '0;
        if (awvalid && awready) begin
            r = -1;
            foreach (grp[i]) begin
                if (golden_field(grp[i], F_ORDER) == 64'(issued_cnt)) begin
                    r = grp[i];
                end
            end
            check_value(64'(r >= 0), 64'(1), "address phase expected");
            if (r >= 0) begin
                check_value(64'(awid), golden_field(r, F_ID), "awid");
                check_value(64'(awaddr), golden_field(r, F_ADDR), "awaddr");
                check_value(64'(awlen), golden_field(r, F_LEN), "awlen");
                exp_bits = client_bit(r);
                cur_rec  = r;
                exp_beat = 0;
            end
            issued_cnt++;
        end
        check_value(64'(wr_req_ack), 64'(exp_bits), "wr_req_ack");
        exp_bits = '0;
        if (wvalid && wready) begin
            check_value(64'(cur_rec >= 0), 64'(1), "data beat inside a burst");
            if (cur_rec >= 0) begin
                r = int'(golden_field(cur_rec, F_LEN));
                check_value(wdata, golden_field(cur_rec, F_BASE) + 64'(exp_beat), "wdata");
                check_value(64'(wlast), 64'(exp_beat == r), "wlast");
                exp_bits = client_bit(cur_rec);
                beats_seen[cur_rec]++;
                if (exp_beat == r) begin            // Burst closed and its response queued
                    resp_rec.push_back(cur_rec);
                    resp_due.push_back(cycle_cnt + int'(golden_field(cur_rec, F_DELAY)));
                    cur_rec = -1;
                end
                exp_beat++;
            end
        end
        check_value(64'(wr_data_rdy), 64'(exp_bits), "wr_data_rdy");
        exp_bits = '0;
        if (b_rec >= 0) begin
            exp_bits = client_bit(b_rec);           // Owner per golden record
            cmpl_seen[b_rec]++;
        end
        check_value(64'(wr_cmpl), 64'(exp_bits), "wr_cmpl");
        // Clients react to their own handshakes
        for (int k = 0; k < N_CLIENTS; k++) begin
            if (wr_req_ack[k]) begin
                cl_req[k] = 1'b0;
            end
            if (wr_data_rdy[k]) begin
                cl_beat[k]++;
            end
        end
    endtask

    task run_cycle();
        @(negedge clk);
        drive_inputs();
        #1;
        sample_outputs();
    endtask

    function automatic logic test_done();
        foreach (grp[i]) begin
            if (cmpl_seen[grp[i]] == 0) begin
                return 1'b0;
            end
        end
        return resp_due.size() == 0;
    endfunction

    task run_test(input int t);
        int c;
        test_errs = 0;
        grp.delete();
        for (int i = 0; i < n_recs; i++) begin
            if (golden_field(i, F_TEST) == 64'(t)) begin
                grp.push_back(i);
                beats_seen[i] = 0;
                cmpl_seen[i]  = 0;
                c             = int'(golden_field(i, F_CLIENT));
                cl_rec[c]     = i;
                cl_beat[c]    = 0;
                cl_req[c]     = 1'b1;               // All clients of a test ask together
            end
        end
        issued_cnt = 0;
        while (!test_done()) begin
            run_cycle();
        end
        repeat (4) begin
            run_cycle();                            // Quiet cycles catch stray pulses
        end
        foreach (grp[i]) begin
            c = grp[i];
            check_value(64'(beats_seen[c]), golden_field(c, F_LEN) + 64'(1), "beat count");
            check_value(64'(cmpl_seen[c]), 64'(1), "completion count");
            cl_rec[int'(golden_field(c, F_CLIENT))] = -1;
        end
        tests_run++;
        if (test_errs != 0) begin
            tests_failed++;
        end
        $display("Test %0d: %0d bursts, %0d errors", t, grp.size(), test_errs);
    endtask

    task automatic check_reset();
        test_errs = 0;
        check_value(64'(awvalid), 64'(0), "awvalid after reset");
        check_value(64'(wvalid), 64'(0), "wvalid after reset");
        check_value(64'(wr_req_ack), 64'(0), "wr_req_ack after reset");
        check_value(64'(wr_data_rdy), 64'(0), "wr_data_rdy after reset");
        check_value(64'(wr_cmpl), 64'(0), "wr_cmpl after reset");
        check_value(64'(bready), 64'(1), "bready after reset");
        tests_run++;
        if (test_errs != 0) begin
            tests_failed++;
        end
        $display("Reset: %0d errors", test_errs);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin
        int recs_found;
        int prev_test;
        int t;
        void'($urandom(76));                        // Fixes the stall pattern
        rst         = 1'b1;
        wr_req      = '0;
        wr_req_id   = '0;
        wr_addr     = '0;
        wr_len      = '0;
        wr_data     = '0;
        wr_data_vld = '0;
        awready     = 1'b0;
        wready      = 1'b0;
        bvalid      = 1'b0;
        bid         = '0;
        cl_req      = '0;
        for (int k = 0; k < N_CLIENTS; k++) begin
            cl_rec[k]  = -1;
            cl_beat[k] = 0;
        end
        for (int i = 0; i < MAX_RECS*N_FIELDS; i++) begin
            golden_mem[i] = '0;                     // Test 0 ends the record list
        end
        $readmemh("tests/golden_wr_bursts.txt", golden_mem);
        recs_found = 0;
        while (recs_found < MAX_RECS && golden_field(recs_found, F_TEST) != 64'(0)) begin
            recs_found++;
        end
        n_recs = recs_found;                        // Final count in one step
        check_value(64'(n_recs > 0), 64'(1), "golden records loaded");
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        check_reset();
        prev_test = 0;
        for (int i = 0; i < n_recs; i++) begin
            t = int'(golden_field(i, F_TEST));
            if (t != prev_test) begin
                run_test(t);
                prev_test = t;
            end
        end
        $display("Tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Budget scales with the longest possible burst per record
    initial begin
        wait (n_recs > 0);
        #(n_recs * (256 + 40) * CLK_PERIOD);
        $display("Timeout: bursts still open after %0d cycles", n_recs * (256 + 40));
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/golden_wr_bursts.txt
// Columns, all hex: test client id addr len data_base order resp_delay
// len is beats minus one, order is the address phase slot within the test
// Test 1 round robin right after reset, pointer at client 0
01 0 1 0000100 03 1000000000000000 0 04
01 1 2 0000200 01 2000000000000000 1 03
01 2 3 0000300 02 3000000000000000 2 02
01 3 4 0000400 00 4000000000000000 3 01
// Test 2 single burst, search starts at client 0
02 2 9 1234560 0F 0000000012340000 0 05
// Test 3 all four again, search starts after client 2
03 0 5 0010000 02 5000000000000000 1 06
03 1 6 0020000 04 6000000000000000 2 02
03 2 7 0030000 01 7000000000000000 3 08
03 3 8 0040000 03 8000000000000000 0 03
// Test 4 three clients, responses in reversed issue order
// Search starts at client 3
04 0 C 0100000 05 9000000000000000 1 20
04 1 D 0200000 02 A000000000000000 2 01
04 3 E 0300000 07 B000000000000000 0 40
// Test 5 all four, shuffled responses
// Search starts at client 2
05 0 0 0400000 01 C000000000000000 2 10
05 1 F 0500000 06 D000000000000000 3 01
05 2 A 0600000 03 E000000000000000 0 30
05 3 B 0700000 00 F000000000000000 1 18
// Test 6 longest burst under random stalls
06 1 3 1FFFFF8 FF 0123456789ABCD00 0 02

// File: filelist.f
hw/axi_bridge_pkg.sv
hw/wr_client_select.sv
hw/wr_burst_counter.sv
hw/wr_channel_fsm.sv
hw/wr_tag_lookaside.sv
hw/axi_wr_bridge_top.sv
tests/tb_axi_wr_bridge.sv

// File: Makefile
# Verilator build and run of the AXI write bridge testbench

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module tb_axi_wr_bridge -f filelist.f -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	@if grep -q "Result: FAILED" sim.log; then exit 1; fi
	@if ! grep -q "Result: PASSED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
